/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_dual_issue_front -f compile.f
	@out="$$(./obj_dir/Vtb_dual_issue_front +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

/* compile.f */
src/front_pkg.sv
src/inst_queue.sv
src/predecode.sv
src/issue.sv
src/id1_reg.sv
src/dual_issue_front.sv
verification/dual_issue_front_asserts.sv
verification/tb_dual_issue_front.sv

/* src/dual_issue_front.sv */
`timescale 1ns/100ps

module dual_issue_front (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    stall,
    input  logic                    push,
    input  front_pkg::fetch_entry_t push_entry,

    output logic                    full,
    output front_pkg::decoded_t     id1_1,
    output front_pkg::decoded_t     id1_2
);

    front_pkg::fetch_entry_t head_1;
    front_pkg::fetch_entry_t head_2;
    logic                    head_1_ok;
    logic                    head_2_ok;
    logic                    pop_1;
    logic                    pop_2;
    front_pkg::decoded_t     lane_1;
    front_pkg::decoded_t     lane_2;

    inst_queue queue0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .push       (push),
        .push_entry (push_entry),
        .pop_1      (pop_1),
        .pop_2      (pop_2),
        .full       (full),
        .head_1     (head_1),
        .head_1_ok  (head_1_ok),
        .head_2     (head_2),
        .head_2_ok  (head_2_ok)
    );

    issue issue0 (
        .stall     (stall),
        .head_1    (head_1),
        .head_1_ok (head_1_ok),
        .head_2    (head_2),
        .head_2_ok (head_2_ok),
        .pop_1     (pop_1),
        .pop_2     (pop_2),
        .lane_1    (lane_1),
        .lane_2    (lane_2)
    );

    id1_reg id1_reg0 (
        .clk    (clk),
        .arst_n (arst_n),
        .stall  (stall),
        .lane_1 (lane_1),
        .lane_2 (lane_2),
        .id1_1  (id1_1),
        .id1_2  (id1_2)
    );

endmodule

/* src/front_pkg.sv */
package front_pkg;

    // ************************************************************************
    // Queue sizing
    // ************************************************************************
    localparam int queue_depth = 8;
    localparam int ptr_w       = $clog2(queue_depth);

    // ************************************************************************
    // MIPS32 opcode and funct encodings
    // ************************************************************************
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_lb      = 6'h20;
    localparam logic [5:0] op_lh      = 6'h21;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_lbu     = 6'h24;
    localparam logic [5:0] op_lhu     = 6'h25;
    localparam logic [5:0] op_sb      = 6'h28;
    localparam logic [5:0] op_sh      = 6'h29;
    localparam logic [5:0] op_sw      = 6'h2b;

    localparam logic [5:0] funct_jr   = 6'h08;
    localparam logic [5:0] funct_jalr = 6'h09;
    localparam logic [5:0] funct_mfhi = 6'h10;
    localparam logic [5:0] funct_mthi = 6'h11;
    localparam logic [5:0] funct_mflo = 6'h12;
    localparam logic [5:0] funct_mtlo = 6'h13;
    localparam logic [5:0] funct_mult = 6'h18;
    localparam logic [5:0] funct_div  = 6'h1a;
    localparam logic [5:0] funct_addu = 6'h21;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_entry_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
        logic [5:0]  op_code;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [5:0]  funct;
        logic        w_reg_ena;
        logic [4:0]  w_reg_dst;
        logic [15:0] imme;
        logic [25:0] j_imme;
        logic        is_branch;
        logic        is_j_imme;
        logic        is_jr;
        logic        is_ls;
        logic        is_hilo;
    } decoded_t;

endpackage

/* src/id1_reg.sv */
`timescale 1ns/100ps

module id1_reg (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                stall,

    input  front_pkg::decoded_t lane_1,
    input  front_pkg::decoded_t lane_2,

    output front_pkg::decoded_t id1_1,
    output front_pkg::decoded_t id1_2
);

    front_pkg::decoded_t pay_1;
    front_pkg::decoded_t pay_2;
    logic                vld_1;
    logic                vld_2;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_1 <= 1'b0;
            vld_2 <= 1'b0;
        end else if (!stall) begin
            vld_1 <= lane_1.valid;
            vld_2 <= lane_2.valid;
        end
    end

    // Payload holds under stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            pay_1 <= lane_1;
            pay_2 <= lane_2;
        end
    end

    always_comb begin
        id1_1       = pay_1;
        id1_1.valid = vld_1;
        id1_2       = pay_2;
        id1_2.valid = vld_2;
    end

endmodule

/* src/inst_queue.sv */
`timescale 1ns/100ps

module inst_queue (
    input  logic                   clk,
    input  logic                   arst_n,

    input  logic                   push,
    input  front_pkg::fetch_entry_t push_entry,

    input  logic                   pop_1,
    input  logic                   pop_2,

    output logic                   full,
    output front_pkg::fetch_entry_t head_1,
    output logic                   head_1_ok,
    output front_pkg::fetch_entry_t head_2,
    output logic                   head_2_ok
);

    front_pkg::fetch_entry_t mem [front_pkg::queue_depth];

    logic [front_pkg::ptr_w-1:0] rd_ptr;
    logic [front_pkg::ptr_w-1:0] wr_ptr;
    logic [front_pkg::ptr_w-1:0] rd_ptr_nxt;
    logic [front_pkg::ptr_w:0]   count;
    logic [front_pkg::ptr_w:0]   pop_cnt;
    logic                        push_ok;

    assign full      = (count == (front_pkg::ptr_w+1)'(front_pkg::queue_depth));
    assign push_ok   = push & ~full;                // Dropped when full
    assign head_1_ok = (count != '0);
    assign head_2_ok = (count >= (front_pkg::ptr_w+1)'(2));

    assign rd_ptr_nxt = rd_ptr + 1'b1;              // Wraps, depth is a power of two
    assign head_1     = mem[rd_ptr];
    assign head_2     = mem[rd_ptr_nxt];

    // Entries retired this cycle, never more than present
    always_comb begin
        pop_cnt = '0;
        if (pop_1 && head_1_ok) begin
            if (pop_2 && head_2_ok) begin
                pop_cnt = (front_pkg::ptr_w+1)'(2);
            end else begin
                pop_cnt = (front_pkg::ptr_w+1)'(1);
            end
        end
    end

    // ************************************************************************
    // Storage
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    // ************************************************************************
    // Pointers and occupancy
    // ************************************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_ptr + pop_cnt[front_pkg::ptr_w-1:0];
            count  <= count + (front_pkg::ptr_w+1)'(push_ok) - pop_cnt;
        end
    end

endmodule

/* src/issue.sv */
`timescale 1ns/100ps

module issue (
    input  logic                    stall,

    input  front_pkg::fetch_entry_t head_1,
    input  logic                    head_1_ok,
    input  front_pkg::fetch_entry_t head_2,
    input  logic                    head_2_ok,

    output logic                    pop_1,
    output logic                    pop_2,

    output front_pkg::decoded_t     lane_1,
    output front_pkg::decoded_t     lane_2
);

    front_pkg::decoded_t dec_1_out;
    front_pkg::decoded_t dec_2_out;

    logic inst_jmp_1;
    logic inst_jmp_2;
    logic raw_conflict;
    logic pair_ok;

    predecode dec_1 (
        .entry (head_1),
        .dec   (dec_1_out)
    );

    predecode dec_2 (
        .entry (head_2),
        .dec   (dec_2_out)
    );

    assign inst_jmp_1 = dec_1_out.is_branch | dec_1_out.is_j_imme | dec_1_out.is_jr;
    assign inst_jmp_2 = dec_2_out.is_branch | dec_2_out.is_j_imme | dec_2_out.is_jr;

    assign raw_conflict = dec_1_out.w_reg_ena &
        (((dec_1_out.w_reg_dst == dec_2_out.rs) && (dec_2_out.rs != 5'h0)) ||
         ((dec_1_out.w_reg_dst == dec_2_out.rt) && (dec_2_out.rt != 5'h0)));

    // Pairing rules, highest priority first
    always_comb begin
        if (inst_jmp_1) begin
            pair_ok = 1'b1;                         // Delay slot goes along
        end else if (raw_conflict || dec_1_out.is_ls || inst_jmp_2 || dec_1_out.is_hilo) begin
            pair_ok = 1'b0;
        end else begin
            pair_ok = 1'b1;
        end
    end

    assign pop_1 = ~stall & head_1_ok;
    assign pop_2 = pop_1 & head_2_ok & pair_ok;

    always_comb begin
        lane_1       = dec_1_out;
        lane_1.valid = pop_1;
        lane_2       = dec_2_out;
        lane_2.valid = pop_2;
    end

endmodule

/* src/predecode.sv */
`timescale 1ns/100ps

module predecode (
    input  front_pkg::fetch_entry_t entry,
    output front_pkg::decoded_t     dec
);

    logic [5:0] op;
    logic [5:0] fn;
    logic       is_special;
    logic       is_load;
    logic       is_store;
    logic       no_write;
    logic [4:0] dst;

    assign op         = entry.inst[31:26];
    assign fn         = entry.inst[5:0];
    assign is_special = (op == front_pkg::op_special);

    assign is_load  = (op == front_pkg::op_lb)  || (op == front_pkg::op_lh) ||
                      (op == front_pkg::op_lw)  || (op == front_pkg::op_lbu) ||
                      (op == front_pkg::op_lhu);
    assign is_store = (op == front_pkg::op_sb)  || (op == front_pkg::op_sh) ||
                      (op == front_pkg::op_sw);

    // Destination: rd for R-type, ra for jal, rt otherwise
    always_comb begin
        if (is_special) begin
            dst = entry.inst[15:11];
        end else if (op == front_pkg::op_jal) begin
            dst = 5'd31;
        end else begin
            dst = entry.inst[20:16];
        end
    end

    always_comb begin
        dec           = '0;
        dec.valid     = 1'b0;                       // Filled in by issue
        dec.pc        = entry.pc;
        dec.inst      = entry.inst;
        dec.op_code   = op;
        dec.rs        = entry.inst[25:21];
        dec.rt        = entry.inst[20:16];
        dec.rd        = entry.inst[15:11];
        dec.sa        = entry.inst[10:6];
        dec.funct     = fn;
        dec.imme      = entry.inst[15:0];
        dec.j_imme    = entry.inst[25:0];

        dec.is_branch = (op == front_pkg::op_regimm) || (op == front_pkg::op_beq) ||
                        (op == front_pkg::op_bne)    || (op == front_pkg::op_blez) ||
                        (op == front_pkg::op_bgtz);
        dec.is_j_imme = (op == front_pkg::op_j) || (op == front_pkg::op_jal);
        dec.is_jr     = is_special &&
                        ((fn == front_pkg::funct_jr) || (fn == front_pkg::funct_jalr));
        dec.is_ls     = is_load || is_store;
        dec.is_hilo   = is_special &&
                        ((fn == front_pkg::funct_mfhi) || (fn == front_pkg::funct_mflo) ||
                         (fn == front_pkg::funct_mthi) || (fn == front_pkg::funct_mtlo) ||
                         (fn == front_pkg::funct_mult) || (fn == front_pkg::funct_div));

        dec.w_reg_dst = dst;
        dec.w_reg_ena = !no_write && (dst != 5'd0);  // $zero is never written
    end

    // Instructions without a GPR result
    assign no_write = is_store ||
                      (op == front_pkg::op_regimm) || (op == front_pkg::op_beq) ||
                      (op == front_pkg::op_bne)    || (op == front_pkg::op_blez) ||
                      (op == front_pkg::op_bgtz)   || (op == front_pkg::op_j) ||
                      (is_special && ((fn == front_pkg::funct_jr) ||
                                      (fn == front_pkg::funct_mthi) ||
                                      (fn == front_pkg::funct_mtlo) ||
                                      (fn == front_pkg::funct_mult) ||
                                      (fn == front_pkg::funct_div)));

endmodule

/* verification/dual_issue_front_asserts.sv */
`timescale 1ns/100ps

module dual_issue_front_asserts (
    input logic                clk,
    input logic                arst_n,
    input logic                stall,
    input logic                push,
    input logic                full,
    input logic                head_2_ok,
    input front_pkg::decoded_t id1_1,
    input front_pkg::decoded_t id1_2
);

    int          fails = 0;
    logic        got_push;
    logic        captured;                          // ID1 loaded at the last edge
    logic        slot_ready;                        // Successor queued when lane 1 issued
    logic        have_prev;
    logic [31:0] prev_pc;
    logic [5:0]  op_1;
    logic        fresh;
    logic        solo_1;
    logic        raw_12;
    logic        no_wb_1;
    logic [4:0]  dst_1;
    int          pushed;
    int          popped;
    int          pending;

    function automatic logic is_jump(input logic [31:0] inst);
        return (inst[31:26] >= front_pkg::op_regimm && inst[31:26] <= front_pkg::op_bgtz) ||
               (inst[31:26] == front_pkg::op_special && inst[5:1] == 5'b00100); // jr, jalr
    endfunction

    task automatic count_failure(input string what);
        fails++;
        $error("%s", what);
    endtask

    assign op_1    = id1_1.inst[31:26];
    assign fresh   = captured && id1_1.valid;
    assign solo_1  = op_1[5] || (op_1 == front_pkg::op_special && id1_1.inst[5:4] == 2'b01);
    assign raw_12  = id1_1.w_reg_ena && (id1_1.w_reg_dst != 5'd0) &&
                     ((id1_1.w_reg_dst == id1_2.inst[25:21]) ||
                      (id1_1.w_reg_dst == id1_2.inst[20:16]));
    assign no_wb_1 = (op_1 >= front_pkg::op_regimm && op_1 <= front_pkg::op_bgtz &&
                      op_1 != front_pkg::op_jal) || (op_1[5:3] == 3'b101);  // Stores
    assign dst_1   = (op_1 == front_pkg::op_special) ? id1_1.inst[15:11] :
                     (op_1 == front_pkg::op_jal)     ? 5'd31 : id1_1.inst[20:16];

    // Queue level from accepted pushes and the lanes popped so far
    assign pending = pushed - popped - (fresh ? 1 + int'(id1_2.valid) : 0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            got_push   <= 1'b0;
            captured   <= 1'b0;
            slot_ready <= 1'b0;
            have_prev  <= 1'b0;
            prev_pc    <= '0;
            pushed     <= 0;
            popped     <= 0;
        end else begin
            got_push <= got_push || (push && !full);
            captured <= !stall;
            pushed   <= pushed + int'(push && !full);
            if (!stall) begin
                slot_ready <= head_2_ok;
            end
            if (fresh) begin
                have_prev <= 1'b1;
                prev_pc   <= id1_2.valid ? id1_2.pc : id1_1.pc;
                popped    <= popped + 1 + int'(id1_2.valid);
            end
        end
    end

    // ************************************************************************
    // Properties
    // ************************************************************************
    idle_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
        !got_push |-> !id1_1.valid && !id1_2.valid) else count_failure("ID1 valid before any push");
    queue_level: assert property (@(posedge clk) disable iff (!arst_n)
        full == (pending == front_pkg::queue_depth) && head_2_ok == (pending >= 2))
        else count_failure("queue full or second head flag does not match the queue level");
    pair_order: assert property (@(posedge clk) disable iff (!arst_n)
        id1_2.valid |-> id1_1.valid && id1_2.pc == id1_1.pc + 32'd4)
        else count_failure("lane 2 valid alone or not the successor of lane 1");
    pc_in_order: assert property (@(posedge clk) disable iff (!arst_n)
        fresh && have_prev |-> id1_1.pc == prev_pc + 32'd4)
        else count_failure("issued instruction lost or out of order");
    pairing: assert property (@(posedge clk) disable iff (!arst_n)
        id1_2.valid && !is_jump(id1_1.inst) |-> !solo_1 && !raw_12 && !is_jump(id1_2.inst))
        else count_failure("pair issued against a pairing rule");
    pair_when_allowed: assert property (@(posedge clk) disable iff (!arst_n)
        fresh && slot_ready && !id1_2.valid |-> solo_1 || raw_12 || is_jump(id1_2.inst))
        else count_failure("lane 1 issued alone although the pair was allowed");
    delay_slot: assert property (@(posedge clk) disable iff (!arst_n)
        fresh && is_jump(id1_1.inst) && slot_ready |-> id1_2.valid)
        else count_failure("jump issued without its queued delay slot");
    stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        stall |=> $stable(id1_1) && $stable(id1_2)) else count_failure("ID1 changed under stall");
    writeback: assert property (@(posedge clk) disable iff (!arst_n)
        id1_1.valid |-> id1_1.w_reg_dst == dst_1 && !(no_wb_1 && id1_1.w_reg_ena))
        else count_failure("lane 1 write-back register or enable is wrong");

endmodule

/* verification/tb_dual_issue_front.sv */
`timescale 1ns/100ps

module tb_dual_issue_front;

    localparam int n_inst    = 400;
    localparam int cycle_max = 4 * n_inst + 100;

    logic                    clk = 1'b0;
    logic                    arst_n;
    logic                    stall;
    logic                    push;
    front_pkg::fetch_entry_t push_entry;
    logic                    full;
    front_pkg::decoded_t     id1_1;
    front_pkg::decoded_t     id1_2;

    logic [31:0] rng    = 32'hdb93f49d;
    logic        captured;
    int          issued;
    int          cycles = 0;
    int          errors = 0;
    int          sent   = 0;
    int          burst  = 0;

    dual_issue_front dut0 (.*);

    bind dual_issue_front dual_issue_front_asserts asserts0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .stall     (stall),
        .push      (push),
        .full      (full),
        .head_2_ok (head_2_ok),
        .id1_1     (id1_1),
        .id1_2     (id1_2)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // $0, $1, $2 and $ra only, so RAW hits are frequent
    function automatic logic [4:0] pick_reg(input logic [1:0] k);
        return (k == 2'd3) ? 5'd31 : 5'(k);
    endfunction

    // ************************************************************************
    // Instruction mix: ALU 7/16, load/store 3/16, branch 2/16, j/jal,
    // jr/jalr 1/16 each, mult/mfhi 2/16
    // ************************************************************************
    function automatic logic [31:0] make_inst(input logic [31:0] r);
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        rs = pick_reg(r[5:4]);
        rt = pick_reg(r[7:6]);
        rd = pick_reg(r[9:8]);
        case (r[3:0])
            4'd6, 4'd7:  return {r[10] ? front_pkg::op_lw : front_pkg::op_sw, rs, rt, r[31:16]};
            4'd8:        return {front_pkg::op_lbu, rs, rt, r[31:16]};
            4'd9, 4'd10: return {r[10] ? front_pkg::op_beq : front_pkg::op_bne, rs, rt, r[31:16]};
            4'd11:       return {r[10] ? front_pkg::op_j : front_pkg::op_jal, r[31:6]};
            4'd12:       return {front_pkg::op_special, rs, 5'd0, r[10] ? rd : 5'd0, 5'd0,
                                 r[10] ? front_pkg::funct_jalr : front_pkg::funct_jr};
            4'd13:       return {front_pkg::op_special, rs, rt, 10'd0, front_pkg::funct_mult};
            4'd14:       return {front_pkg::op_special, 10'd0, rd, 5'd0, front_pkg::funct_mfhi};
            4'd15:       return {front_pkg::op_addiu, rs, rt, r[31:16]};
            default:     return {front_pkg::op_special, rs, rt, rd, 5'd0, front_pkg::funct_addu};
        endcase
    endfunction

    // ID1 shows new lanes after an edge where stall was low
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            captured <= 1'b0;
            issued   <= 0;
        end else begin
            captured <= !stall;
            if (captured) begin
                issued <= issued + int'(id1_1.valid) + int'(id1_2.valid);
            end
        end
    end

    initial begin
        while (cycles < cycle_max) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, only %0d of %0d instructions issued",
                 cycles, issued, n_inst);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        arst_n     = 1'b0;
        stall      = 1'b0;
        push       = 1'b0;
        push_entry = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        while (issued < n_inst) begin
            @(negedge clk);
            rng = xorshift(rng);
            if (burst != 0) begin
                burst = burst - 1;
            end else if (rng[3:0] == 4'd0) begin
                burst = 1 + int'(rng[6:4]);          // Stall burst of 1 to 8 cycles
            end
            stall = (burst != 0);
            push  = (sent < n_inst) && !full;
            if (push) begin
                rng             = xorshift(rng);
                push_entry.pc   = 32'h0040_0000 + 32'(sent * 4);
                push_entry.inst = make_inst(rng);
                sent++;
            end
        end
        push  = 1'b0;
        stall = 1'b0;
        repeat (4) @(negedge clk);
        if (issued != n_inst) begin
            errors++;
            $display("Error issued_count expected %0d actual %0d", n_inst, issued);
        end
        $display("Run complete: %0d testbench errors, %0d assertion failures",
                 errors, dut0.asserts0.fails);
        if (errors == 0 && dut0.asserts0.fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
